// File: dv/tb_pkt_fifo.sv
`default_nettype none

module tb_pkt_fifo;

    logic                     clk_wr;
    logic                     clk_rd;
    logic                     i_rst_n;
    logic                     i_wr_en;
    pkt_fifo_pkg::fifo_word_t i_wr_word;
    logic                     i_latch_addr;
    logic                     i_drop_pckt;
    pkt_fifo_pkg::wr_status_t o_wr_status;
    logic                     i_rd_en;
    pkt_fifo_pkg::fifo_word_t o_rd_word;
    logic                     o_rd_valid;
    pkt_fifo_pkg::rd_status_t o_rd_status;

    // Committed words in read order, and bytes of the packet still open
    pkt_fifo_pkg::fifo_word_t ref_q[$];
    pkt_fifo_pkg::fifo_word_t pend_q[$];
    pkt_fifo_pkg::fifo_word_t exp_word;

    int seed = 77642;
    int errors = 0;
    int rd_count = 0;
    int wr_cycles = 0;

    pkt_fifo DUT (.*);

    initial
    begin
        clk_wr = 1'b0;
        forever #2 clk_wr = ~clk_wr;
    end

    // Odd ratio keeps the two domains drifting
    initial
    begin
        clk_rd = 1'b0;
        forever #3 clk_rd = ~clk_rd;
    end

    // Longest run is about 1200 writes plus reads and waits, limit is four times that
    always @(posedge clk_wr)
    begin
        wr_cycles++;
        if (wr_cycles >= 20000)
        begin
            $display("Timeout, the run went past its clk_wr cycle limit");
            $display("Errors: %0d, words read: %0d", errors, rd_count);
            $display("Simulation failed");
            $finish;
        end
    end

    // Every valid word pops the oldest committed word
    always @(negedge clk_rd)
    begin
        if (o_rd_valid)
        begin
            rd_count++;
            assert (ref_q.size() > 0)
            else
            begin
                errors++;
                $display("Read data appeared with no committed word left to match");
            end
            if (ref_q.size() > 0)
            begin
                exp_word = ref_q.pop_front();
                assert (o_rd_word == exp_word)
                else
                begin
                    errors++;
                    $display("CHECK FAILED o_rd_word expected %h got %h", exp_word, o_rd_word);
                end
            end
        end
    end

    task automatic check_value(input string name, input int exp, input int act);
        assert (exp == act)
        else
        begin
            errors++;
            $display("CHECK FAILED %s expected %h got %h", name, exp, act);
        end
    endtask

    // Open packet becomes visible to the reference
    task automatic commit_pending();
        foreach (pend_q[k])
            ref_q.push_back(pend_q[k]);
        pend_q.delete();
    endtask

    // Writes len random bytes, last flag on the final one
    // Optional commit rides on the last byte
    task automatic write_bytes(input int len, input bit commit, input bit check);
        logic [31:0]              rnd;
        pkt_fifo_pkg::fifo_word_t word;
        for (int i = 0; i <= len; i++)
        begin
            @(posedge clk_wr);
            #1;
            // i bytes accepted so far, exact only while nothing is read
            if (check)
            begin
                check_value("o_wr_status.full", int'(i == pkt_fifo_pkg::FIFO_DEPTH),
                            int'(o_wr_status.full));
                check_value("o_wr_status.almost_full",
                            int'(i >= pkt_fifo_pkg::FIFO_DEPTH - pkt_fifo_pkg::ALMOST_FULL_DIFF),
                            int'(o_wr_status.almost_full));
            end
            i_wr_en = 1'b0;
            i_latch_addr = 1'b0;
            if (i == len)
                break;
            // Writer side of the handshake
            while (o_wr_status.full)
            begin
                @(posedge clk_wr);
                #1;
            end
            rnd = $random(seed);
            word.data = rnd[pkt_fifo_pkg::DATA_WIDTH-1:0];
            word.last = (i == len - 1);
            i_wr_word = word;
            i_wr_en = 1'b1;
            pend_q.push_back(word);
            if (commit && word.last)
            begin
                i_latch_addr = 1'b1;
                commit_pending();
            end
        end
    endtask

    // One-cycle commit or drop pulse with no write
    task automatic end_packet(input bit drop);
        @(posedge clk_wr);
        #1;
        if (drop)
        begin
            i_drop_pckt = 1'b1;
            pend_q.delete();
        end
        else
        begin
            i_latch_addr = 1'b1;
            commit_pending();
        end
        @(posedge clk_wr);
        #1;
        i_drop_pckt = 1'b0;
        i_latch_addr = 1'b0;
    endtask

    task automatic wait_not_empty(input int bound);
        int n;
        n = 0;
        @(posedge clk_rd);
        #1;
        while (o_rd_status.empty && n < bound)
        begin
            @(posedge clk_rd);
            #1;
            n++;
        end
        assert (!o_rd_status.empty)
        else
        begin
            errors++;
            $display("Committed data did not reach the read side within %0d cycles", bound);
        end
    endtask

    // Reads until empty, then checks how many words came out
    task automatic drain_fifo(input int n_expect, input bit check);
        int issued;
        int first_count;
        issued = 0;
        first_count = rd_count;
        @(posedge clk_rd);
        #1;
        while (!o_rd_status.empty)
        begin
            if (check)
                check_value("o_rd_status.almost_empty",
                            int'(n_expect - issued <= pkt_fifo_pkg::ALMOST_EMPTY_DIFF),
                            int'(o_rd_status.almost_empty));
            i_rd_en = 1'b1;
            issued++;
            @(posedge clk_rd);
            #1;
        end
        i_rd_en = 1'b0;
        // Last word still has to pass the monitor
        repeat (2) @(posedge clk_rd);
        #1;
        check_value("read count", n_expect, rd_count - first_count);
        check_value("reference queue size", 0, ref_q.size());
    endtask

    task automatic check_reset_state();
        check_value("o_rd_status.empty", 1, int'(o_rd_status.empty));
        check_value("o_rd_status.almost_empty", 1, int'(o_rd_status.almost_empty));
        check_value("o_wr_status.full", 0, int'(o_wr_status.full));
        check_value("o_wr_status.almost_full", 0, int'(o_wr_status.almost_full));
        check_value("o_rd_valid", 0, int'(o_rd_valid));
    endtask

    task automatic send_committed_packet();
        write_bytes(10, 1'b1, 1'b0);
        wait_not_empty(20);
        drain_fifo(10, 1'b0);
    endtask

    // Bytes past the commit point stay hidden from the reader
    task automatic hold_uncommitted();
        write_bytes(5, 1'b0, 1'b0);
        repeat (20)
        begin
            @(posedge clk_rd);
            #1;
            check_value("o_rd_status.empty", 1, int'(o_rd_status.empty));
        end
        end_packet(1'b0);
        wait_not_empty(20);
        drain_fifo(5, 1'b0);
    endtask

    // Packet B is rewound, A and C come out back to back
    task automatic drop_middle_packet();
        write_bytes(6, 1'b1, 1'b0);
        write_bytes(4, 1'b0, 1'b0);
        end_packet(1'b1);
        write_bytes(7, 1'b1, 1'b0);
        wait_not_empty(20);
        // Commit of C may still be crossing
        repeat (5) @(posedge clk_rd);
        drain_fifo(13, 1'b0);
    endtask

    task automatic fill_and_drain();
        // Read pointer of earlier tests settles on the write side
        repeat (8) @(posedge clk_wr);
        write_bytes(pkt_fifo_pkg::FIFO_DEPTH, 1'b1, 1'b1);
        // Extra write against full, committed at once
        // An accepted write would come out as one word too many
        i_wr_word = '1;
        i_wr_en = 1'b1;
        i_latch_addr = 1'b1;
        @(posedge clk_wr);
        #1;
        i_wr_en = 1'b0;
        i_latch_addr = 1'b0;
        check_value("o_wr_status.full", 1, int'(o_wr_status.full));
        wait_not_empty(20);
        drain_fifo(pkt_fifo_pkg::FIFO_DEPTH, 1'b1);
    endtask

    // Random packets and drops against a random reader
    task automatic run_mixed_traffic();
        logic [31:0] rnd;
        logic [31:0] rd_rnd;
        int          len;
        bit          wr_done;
        wr_done = 1'b0;
        fork
            begin
                for (int p = 0; p < 20; p++)
                begin
                    rnd = $random(seed);
                    len = 1 + int'(rnd[15:0]) % 40;
                    // About one packet in four is dropped
                    write_bytes(len, rnd[17:16] != 2'b00, 1'b0);
                    if (rnd[17:16] == 2'b00)
                        end_packet(1'b1);
                end
                wr_done = 1'b1;
            end
            begin
                @(posedge clk_rd);
                #1;
                while (!(wr_done && ref_q.size() == 0 && o_rd_status.empty))
                begin
                    rd_rnd = $random(seed);
                    i_rd_en = !o_rd_status.empty && rd_rnd[0];
                    @(posedge clk_rd);
                    #1;
                end
                i_rd_en = 1'b0;
            end
        join
    endtask

    initial
    begin
        i_rst_n = 1'b0;
        i_wr_en = 1'b0;
        i_wr_word = '0;
        i_latch_addr = 1'b0;
        i_drop_pckt = 1'b0;
        i_rd_en = 1'b0;
        repeat (16) @(posedge clk_wr);
        #1;
        i_rst_n = 1'b1;
        check_reset_state();
        send_committed_packet();
        hold_uncommitted();
        drop_middle_packet();
        fill_and_drain();
        run_mixed_traffic();
        $display("Errors: %0d, words read: %0d", errors, rd_count);
        if (errors == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
hw/pkt_fifo_pkg.sv
hw/pkt_fifo_mem.sv
hw/pkt_fifo_wr_ctrl.sv
hw/pkt_fifo_rd_ctrl.sv
hw/ptr_sync.sv
hw/pkt_fifo.sv
dv/tb_pkt_fifo.sv

// File: hw/pkt_fifo.sv
`default_nettype none

module pkt_fifo
(
    input  wire                          clk_wr,
    input  wire                          clk_rd,
    input  wire                          i_rst_n,

    // Write side, clk_wr
    input  wire                          i_wr_en,
    input  wire  pkt_fifo_pkg::fifo_word_t i_wr_word,
    input  wire                          i_latch_addr,
    input  wire                          i_drop_pckt,
    output pkt_fifo_pkg::wr_status_t     o_wr_status,

    // Read side, clk_rd
    input  wire                          i_rd_en,
    output pkt_fifo_pkg::fifo_word_t     o_rd_word,
    output logic                         o_rd_valid,
    output pkt_fifo_pkg::rd_status_t     o_rd_status
);

    // Write domain nets
    logic                                mem_wr_en;
    logic [pkt_fifo_pkg::ADDR_WIDTH-1:0] wr_addr;
    pkt_fifo_pkg::ptr_t                  commit_ptr;
    pkt_fifo_pkg::ptr_t                  rd_ptr_wr;

    // Read domain nets
    logic                                mem_rd_en;
    logic [pkt_fifo_pkg::ADDR_WIDTH-1:0] rd_addr;
    pkt_fifo_pkg::ptr_t                  rd_ptr;
    pkt_fifo_pkg::ptr_t                  commit_ptr_rd;

    // Dual-clock block RAM
    pkt_fifo_mem fifo_bram (
        .i_clk_wr  (clk_wr),
        .i_clk_rd  (clk_rd),
        .i_wr_en   (mem_wr_en),
        .i_wr_addr (wr_addr),
        .i_wr_word (i_wr_word),
        .i_rd_en   (mem_rd_en),
        .i_rd_addr (rd_addr),
        .o_rd_word (o_rd_word)
    );

    // Write pointer, commit and drop
    pkt_fifo_wr_ctrl wr_ctrl (
        .clk_wr       (clk_wr),
        .i_rst_n      (i_rst_n),
        .i_wr_en      (i_wr_en),
        .i_latch_addr (i_latch_addr),
        .i_drop_pckt  (i_drop_pckt),
        .i_rd_ptr     (rd_ptr_wr),
        .o_mem_wr_en  (mem_wr_en),
        .o_wr_addr    (wr_addr),
        .o_commit_ptr (commit_ptr),
        .o_wr_status  (o_wr_status)
    );

    // Read pointer and valid
    pkt_fifo_rd_ctrl rd_ctrl (
        .clk_rd       (clk_rd),
        .i_rst_n      (i_rst_n),
        .i_rd_en      (i_rd_en),
        .i_commit_ptr (commit_ptr_rd),
        .o_mem_rd_en  (mem_rd_en),
        .o_rd_addr    (rd_addr),
        .o_rd_ptr     (rd_ptr),
        .o_rd_valid   (o_rd_valid),
        .o_rd_status  (o_rd_status)
    );

    // Only the committed pointer crosses, so dropped bytes stay hidden
    ptr_sync w2r_sync (
        .i_clk_src (clk_wr),
        .i_clk_dst (clk_rd),
        .i_rst_n   (i_rst_n),
        .i_ptr     (commit_ptr),
        .o_ptr     (commit_ptr_rd)
    );

    // Read pointer back into the write domain for the full flags
    ptr_sync r2w_sync (
        .i_clk_src (clk_rd),
        .i_clk_dst (clk_wr),
        .i_rst_n   (i_rst_n),
        .i_ptr     (rd_ptr),
        .o_ptr     (rd_ptr_wr)
    );

endmodule

`default_nettype wire

// File: hw/pkt_fifo_mem.sv
`default_nettype none

module pkt_fifo_mem
(
    input  wire                                  i_clk_wr,
    input  wire                                  i_clk_rd,

    // Write port, already gated against full by the write controller
    input  wire                                  i_wr_en,
    input  wire  [pkt_fifo_pkg::ADDR_WIDTH-1:0]  i_wr_addr,
    input  wire  pkt_fifo_pkg::fifo_word_t       i_wr_word,

    // Read port, already gated against empty by the read controller
    input  wire                                  i_rd_en,
    input  wire  [pkt_fifo_pkg::ADDR_WIDTH-1:0]  i_rd_addr,
    output pkt_fifo_pkg::fifo_word_t             o_rd_word
);

    // Storage array, no reset so it maps onto block RAM
    pkt_fifo_pkg::fifo_word_t mem [pkt_fifo_pkg::FIFO_DEPTH];

    // Synchronous write in the clk_wr domain
    always_ff @(posedge i_clk_wr)
    begin
        if (i_wr_en)
            mem[i_wr_addr] <= i_wr_word;
    end

    // Registered read in the clk_rd domain
    // Output holds its value between reads
    always_ff @(posedge i_clk_rd)
    begin
        if (i_rd_en)
            o_rd_word <= mem[i_rd_addr];
    end

endmodule

`default_nettype wire

// File: hw/pkt_fifo_pkg.sv
`default_nettype none

package pkt_fifo_pkg;

    // Payload is one byte per FIFO entry
    localparam int DATA_WIDTH = 8;

    // Number of entries in the block RAM
    localparam int FIFO_DEPTH = 256;

    // Memory address width, derived from the depth
    localparam int ADDR_WIDTH = $clog2(FIFO_DEPTH);

    // Free space at or below this raises almost_full
    localparam int ALMOST_FULL_DIFF = 50;

    // Committed occupancy at or below this raises almost_empty
    localparam int ALMOST_EMPTY_DIFF = 50;

    // Pointer with one extra wrap bit to tell full from empty
    typedef logic [ADDR_WIDTH:0] ptr_t;

    // One FIFO entry
    typedef struct packed {
        logic                  last;   // final byte of a packet
        logic [DATA_WIDTH-1:0] data;
    } fifo_word_t;

    // Write-side status
    typedef struct packed {
        logic full;
        logic almost_full;
    } wr_status_t;

    // Read-side status
    typedef struct packed {
        logic empty;
        logic almost_empty;
    } rd_status_t;

endpackage

`default_nettype wire

// File: hw/pkt_fifo_rd_ctrl.sv
`default_nettype none

module pkt_fifo_rd_ctrl
(
    input  wire                                  clk_rd,
    input  wire                                  i_rst_n,

    // Reader handshake
    input  wire                                  i_rd_en,

    // Committed write pointer, already synchronized into clk_rd
    input  wire  pkt_fifo_pkg::ptr_t             i_commit_ptr,

    // Memory read port
    output logic                                 o_mem_rd_en,
    output logic [pkt_fifo_pkg::ADDR_WIDTH-1:0]  o_rd_addr,

    // Read pointer toward the write domain
    output pkt_fifo_pkg::ptr_t                   o_rd_ptr,

    // High in the cycle the RAM output holds the popped word
    output logic                                 o_rd_valid,
    output pkt_fifo_pkg::rd_status_t             o_rd_status
);

    // Committed entries not yet read
    pkt_fifo_pkg::ptr_t avail;

    logic rd_accept;

    // Empty follows the local pointer at once and clears late
    always_comb
    begin
        avail = i_commit_ptr - o_rd_ptr;
        o_rd_status.empty = (avail == '0);
        o_rd_status.almost_empty =
            (avail <= pkt_fifo_pkg::ptr_t'(pkt_fifo_pkg::ALMOST_EMPTY_DIFF));
    end

    // A read while empty is ignored
    assign rd_accept   = i_rd_en && !o_rd_status.empty;
    assign o_mem_rd_en = rd_accept;
    assign o_rd_addr   = o_rd_ptr[pkt_fifo_pkg::ADDR_WIDTH-1:0];

    // Pointer advance, valid lines up with the registered RAM read
    always_ff @(posedge clk_rd or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            o_rd_ptr   <= '0;
            o_rd_valid <= 1'b0;
        end
        else
        begin
            o_rd_ptr   <= o_rd_ptr + pkt_fifo_pkg::ptr_t'(rd_accept);
            o_rd_valid <= rd_accept;
        end
    end

endmodule

`default_nettype wire

// File: hw/pkt_fifo_wr_ctrl.sv
`default_nettype none

module pkt_fifo_wr_ctrl
(
    input  wire                                  clk_wr,
    input  wire                                  i_rst_n,

    // Writer handshake and packet control
    input  wire                                  i_wr_en,
    input  wire                                  i_latch_addr,
    input  wire                                  i_drop_pckt,

    // Read pointer, already synchronized into clk_wr
    input  wire  pkt_fifo_pkg::ptr_t             i_rd_ptr,

    // Memory write port
    output logic                                 o_mem_wr_en,
    output logic [pkt_fifo_pkg::ADDR_WIDTH-1:0]  o_wr_addr,

    // Commit point, the only write pointer the reader ever sees
    output pkt_fifo_pkg::ptr_t                   o_commit_ptr,
    output pkt_fifo_pkg::wr_status_t             o_wr_status
);

    // Working pointer, moves with every accepted write
    pkt_fifo_pkg::ptr_t wr_ptr;
    pkt_fifo_pkg::ptr_t wr_ptr_next;

    // Entries held between working pointer and read pointer
    pkt_fifo_pkg::ptr_t used;

    logic wr_accept;

    // Occupancy includes uncommitted bytes since they hold RAM space
    always_comb
    begin
        used = wr_ptr - i_rd_ptr;
        o_wr_status.full = (used == pkt_fifo_pkg::ptr_t'(pkt_fifo_pkg::FIFO_DEPTH));
        o_wr_status.almost_full =
            (used >= pkt_fifo_pkg::ptr_t'(pkt_fifo_pkg::FIFO_DEPTH -
                                          pkt_fifo_pkg::ALMOST_FULL_DIFF));
    end

    // Write only when not full, and never in a drop cycle
    always_comb
    begin
        wr_accept   = i_wr_en && !o_wr_status.full && !i_drop_pckt;
        wr_ptr_next = wr_ptr + pkt_fifo_pkg::ptr_t'(wr_accept);
    end

    assign o_mem_wr_en = wr_accept;

    // Wrap bit dropped for the RAM address
    assign o_wr_addr = wr_ptr[pkt_fifo_pkg::ADDR_WIDTH-1:0];

    // Drop wins over commit and over a write in the same cycle
    // Commit captures the pointer including this cycle's write
    always_ff @(posedge clk_wr or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            wr_ptr       <= '0;
            o_commit_ptr <= '0;
        end
        else if (i_drop_pckt)
        begin
            // Rewind to the last commit point
            wr_ptr <= o_commit_ptr;
        end
        else
        begin
            wr_ptr <= wr_ptr_next;
            if (i_latch_addr)
                o_commit_ptr <= wr_ptr_next;
        end
    end

endmodule

`default_nettype wire

// File: hw/ptr_sync.sv
`default_nettype none

module ptr_sync
(
    input  wire                       i_clk_src,
    input  wire                       i_clk_dst,
    input  wire                       i_rst_n,
    input  wire  pkt_fifo_pkg::ptr_t  i_ptr,
    output pkt_fifo_pkg::ptr_t        o_ptr
);

    // Gray copy in the source domain, so the crossing bus is glitch free
    pkt_fifo_pkg::ptr_t gray_src;

    // Two-flop synchronizer in the destination domain
    pkt_fifo_pkg::ptr_t gray_meta;
    pkt_fifo_pkg::ptr_t gray_sync;

    always_ff @(posedge i_clk_src or negedge i_rst_n)
    begin
        if (!i_rst_n)
            gray_src <= '0;
        else
            gray_src <= i_ptr ^ (i_ptr >> 1);
    end

    always_ff @(posedge i_clk_dst or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            gray_meta <= '0;
            gray_sync <= '0;
        end
        else
        begin
            gray_meta <= gray_src;
            gray_sync <= gray_meta;
        end
    end

    // Binary bit i is the XOR of all Gray bits from i upward
    always_comb
    begin
        for (int i = 0; i <= pkt_fifo_pkg::ADDR_WIDTH; i++)
            o_ptr[i] = ^(gray_sync >> i);
    end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the packet FIFO testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --top-module tb_pkt_fifo \
    -f files.f \
    -Mdir obj_dir -o sim_pkt_fifo
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_output=$(./obj_dir/sim_pkt_fifo)
sim_status=$?
echo "$sim_output"
if [ $sim_status -ne 0 ]; then
    echo "Simulator exited with status $sim_status"
    exit 1
fi

# Pass only if the testbench printed its pass line
if echo "$sim_output" | grep -qxF "Simulation completed successfully"; then
    exit 0
fi
exit 1
